// ==== bench/fetch_tb.sv ====
`include "fetch_macros.svh"

module fetch_tb
   import fetch_pkg::*;
();

   localparam int WAIT_LIMIT = 200;
   localparam int DEPTH      = 1 << `FETCH_IMEM_AW;

   logic       clk_i;
   logic       rst_i;
   word_t      s_awaddr_i, s_wdata_i, s_araddr_i, s_rdata_o;
   logic [3:0] s_wstrb_i;
   logic       s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o;
   logic       s_bvalid_o, s_bready_i, s_arvalid_i, s_arready_o, s_rvalid_o, s_rready_i;
   axi_resp_t  s_bresp_o, s_rresp_o;
   logic       data_busywait_i, branch_toggle_i, ins_busywait_o;
   pc_t        branch_pc_i, issue_pc_o;
   logic       issue_valid_o, issue_ready_i;
   instr_t     issue_instr_o;

   // Reference state
   word_t      shadow [DEPTH];
   pc_t        exp_pc = '0;
   pc_t        target_pc = '0;
   logic       redirect_pending = 1'b0;
   logic       random_ready = 1'b0;
   integer     seed = 32'hff67;
   int         errors = 0;
   int         timeouts = 0;
   int         items = 0;
   int         nops_seen = 0;
   int         redirects = 0;

   fetch_top dut0 (.*);

   initial begin
      clk_i = 1'b0;
      forever begin
         #5 clk_i = ~clk_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // Compare tasks and reference model
   ////////////////////////////////////////////////////////////

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[FAIL] %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_instr(input string name, input instr_t got, input instr_t exp);
      if (got !== exp) begin
         $display("[FAIL] %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_pc(input string name, input pc_t got, input pc_t exp);
      if (got !== exp) begin
         $display("[FAIL] %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("[FAIL] %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
      if (got !== exp) begin
         $display("[FAIL] %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   // Memory word without its opcode tail, or a NOP for a redirected slot
   function automatic instr_t expected_instr(input pc_t pc, input logic redirect);
      word_t word;
      if (redirect) begin
         return `FETCH_NOP_INSTR;
      end
      word = shadow[pc[`FETCH_IMEM_AW-1:0]];
      return word[31:2];
   endfunction

   // Each transfer toward decode completes at the next rising edge
   always @(negedge clk_i) begin
      logic is_nop;
      if (rst_i && issue_valid_o && issue_ready_i) begin
         is_nop = redirect_pending && (issue_instr_o == `FETCH_NOP_INSTR);
         check_pc("issue_pc_o", issue_pc_o, exp_pc);
         check_instr("issue_instr_o", issue_instr_o, expected_instr(exp_pc, is_nop));
         if (is_nop) begin
            nops_seen++;
            redirect_pending = 1'b0;
            exp_pc = target_pc;
         end else begin
            exp_pc = exp_pc + pc_t'(1);
         end
         items++;
      end
   end

   always @(posedge clk_i) begin
      if (random_ready) begin
         issue_ready_i <= ($random(seed) & 1) != 0;
      end else begin
         issue_ready_i <= 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Host bus and pipeline helpers
   ////////////////////////////////////////////////////////////

   task automatic axi_write(input word_t addr, input word_t data, output axi_resp_t resp);
      logic aw_done, w_done, aw_hit, w_hit, b_done;
      int   t;
      aw_done = 1'b0;
      w_done  = 1'b0;
      b_done  = 1'b0;
      resp    = AXI_SLVERR;
      @(posedge clk_i);
      s_awaddr_i  <= addr;
      s_awvalid_i <= 1'b1;
      s_wdata_i   <= data;
      s_wvalid_i  <= 1'b1;
      for (t = 0; t < WAIT_LIMIT && !(aw_done && w_done); t++) begin
         @(negedge clk_i);
         aw_hit = !aw_done && s_awready_o;
         w_hit  = !w_done && s_wready_o;
         @(posedge clk_i);
         if (aw_hit) begin
            s_awvalid_i <= 1'b0;
            aw_done = 1'b1;
         end
         if (w_hit) begin
            s_wvalid_i <= 1'b0;
            w_done = 1'b1;
         end
      end
      s_awvalid_i <= 1'b0;
      s_wvalid_i  <= 1'b0;
      if (!(aw_done && w_done)) begin
         $display("Timeout waiting for AW or W ready at address %h", addr);
         timeouts++;
      end
      for (t = 0; t < WAIT_LIMIT && !b_done; t++) begin
         @(negedge clk_i);
         // Ready is a single cycle pulse per transfer
         check_flag("s_awready_o", s_awready_o, 1'b0);
         check_flag("s_wready_o", s_wready_o, 1'b0);
         if (s_bvalid_o) begin
            resp   = s_bresp_o;
            b_done = 1'b1;
         end
      end
      if (!b_done) begin
         $display("Timeout waiting for the write response at address %h", addr);
         timeouts++;
      end
      @(posedge clk_i);
   endtask

   task automatic axi_read(input word_t addr, output word_t data, output axi_resp_t resp);
      logic ar_done, r_done;
      int   t;
      ar_done = 1'b0;
      r_done  = 1'b0;
      data    = '0;
      resp    = AXI_SLVERR;
      @(posedge clk_i);
      s_araddr_i  <= addr;
      s_arvalid_i <= 1'b1;
      for (t = 0; t < WAIT_LIMIT && !ar_done; t++) begin
         @(negedge clk_i);
         ar_done = s_arready_o;
         @(posedge clk_i);
      end
      s_arvalid_i <= 1'b0;
      if (!ar_done) begin
         $display("Timeout waiting for AR ready at address %h", addr);
         timeouts++;
      end
      for (t = 0; t < WAIT_LIMIT && !r_done; t++) begin
         @(negedge clk_i);
         check_flag("s_arready_o", s_arready_o, 1'b0);
         if (s_rvalid_o) begin
            data   = s_rdata_o;
            resp   = s_rresp_o;
            r_done = 1'b1;
         end
      end
      if (!r_done) begin
         $display("Timeout waiting for read data at address %h", addr);
         timeouts++;
      end
      @(posedge clk_i);
   endtask

   task automatic wait_items(input int count);
      int t;
      for (t = 0; t < WAIT_LIMIT + count * 8 && items < count; t++) begin
         @(posedge clk_i);
      end
      if (items < count) begin
         $display("Timeout waiting for %0d issued items, only %0d arrived", count, items);
         timeouts++;
      end
   endtask

   // Flip the toggle and hold the target until the stage takes it
   task automatic do_redirect(input pc_t target);
      int t;
      @(posedge clk_i);
      target_pc        = target;
      redirect_pending = 1'b1;
      redirects++;
      branch_pc_i     <= target;
      branch_toggle_i <= ~branch_toggle_i;
      @(negedge clk_i);
      check_flag("ins_busywait_o", ins_busywait_o, 1'b1);
      for (t = 0; t < WAIT_LIMIT && ins_busywait_o; t++) begin
         @(negedge clk_i);
      end
      if (ins_busywait_o) begin
         $display("Timeout waiting for the redirect to %h to be accepted", target);
         timeouts++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial begin
      word_t     word;
      word_t     rdata;
      axi_resp_t resp;
      int        i;
      int        t;
      rst_i           = 1'b0;
      s_awaddr_i      = '0;
      s_awvalid_i     = 1'b0;
      s_wdata_i       = '0;
      s_wstrb_i       = 4'hf;
      s_wvalid_i      = 1'b0;
      s_bready_i      = 1'b1;
      s_araddr_i      = '0;
      s_arvalid_i     = 1'b0;
      s_rready_i      = 1'b1;
      data_busywait_i = 1'b1;
      branch_toggle_i = 1'b0;
      branch_pc_i     = '0;
      issue_ready_i   = 1'b1;

      repeat (7) begin
         @(negedge clk_i);
         check_flag("issue_valid_o", issue_valid_o, 1'b0);
         check_flag("ins_busywait_o", ins_busywait_o, 1'b0);
         check_flag("s_bvalid_o", s_bvalid_o, 1'b0);
         check_flag("s_rvalid_o", s_rvalid_o, 1'b0);
      end
      @(posedge clk_i);
      rst_i <= 1'b1;
      @(negedge clk_i);
      check_flag("issue_valid_o", issue_valid_o, 1'b0);
      check_flag("ins_busywait_o", ins_busywait_o, 1'b0);
      check_flag("s_bvalid_o", s_bvalid_o, 1'b0);
      check_flag("s_rvalid_o", s_rvalid_o, 1'b0);

      // Program words never look like the inserted NOP
      for (i = 0; i < DEPTH; i++) begin
         word = $random(seed);
         word[1:0] = 2'b11;
         if (word[31:2] == `FETCH_NOP_INSTR) begin
            word[31] = 1'b1;
         end
         shadow[i] = word;
         axi_write(word_t'(i * 4), word, resp);
         check_resp("s_bresp_o", resp, AXI_OKAY);
      end
      for (i = 0; i < DEPTH; i++) begin
         axi_read(word_t'(i * 4), rdata, resp);
         check_word("s_rdata_o", rdata, shadow[i]);
         check_resp("s_rresp_o", resp, AXI_OKAY);
      end

      // Index 64 aliases word 0 in its low bits, which must stay intact
      axi_write(word_t'(DEPTH * 4), 32'hdead_beef, resp);
      check_resp("s_bresp_o", resp, AXI_SLVERR);
      axi_read(word_t'(DEPTH * 4), rdata, resp);
      check_resp("s_rresp_o", resp, AXI_SLVERR);
      check_word("s_rdata_o", rdata, 32'h0);
      axi_read(32'h0, rdata, resp);
      check_word("s_rdata_o", rdata, shadow[0]);

      // Sequential fetch past the end of memory
      @(posedge clk_i);
      data_busywait_i <= 1'b0;
      wait_items(DEPTH + 16);

      @(negedge clk_i);
      random_ready = 1'b1;
      do_redirect(30'h0123_4038);
      wait_items(items + 24);
      do_redirect(30'h2000_0005);
      wait_items(items + 24);

      // Busywait hold once the buffer has drained
      @(posedge clk_i);
      data_busywait_i <= 1'b1;
      repeat (3) @(negedge clk_i);
      for (t = 0; t < WAIT_LIMIT && issue_valid_o; t++) begin
         @(negedge clk_i);
      end
      if (issue_valid_o) begin
         $display("Timeout waiting for the issue buffer to drain under busywait");
         timeouts++;
      end
      repeat (10) begin
         @(negedge clk_i);
         check_flag("issue_valid_o", issue_valid_o, 1'b0);
      end
      @(posedge clk_i);
      data_busywait_i <= 1'b0;
      wait_items(items + 16);

      @(negedge clk_i);
      check_flag("ins_busywait_o", ins_busywait_o, 1'b0);
      if (nops_seen != redirects) begin
         $display("Saw %0d NOP items for %0d redirects", nops_seen, redirects);
         errors++;
      end

      $display("Errors %0d, timeouts %0d, items checked %0d", errors, timeouts, items);
      if (errors == 0 && timeouts == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== src/fetch_issue_buffer.sv ====
`include "fetch_macros.svh"

module fetch_issue_buffer
   import fetch_pkg::*;
(
   input  logic   clk_i,
   input  logic   rst_i,

   // From the fetch stage
   input  logic   push_i,
   input  pc_t    push_pc_i,
   input  instr_t push_instr_i,
   output logic   stall_o,

   // Toward decode
   output logic   issue_valid_o,
   output pc_t    issue_pc_o,
   output instr_t issue_instr_o,
   input  logic   issue_ready_i
);

   localparam int DEPTH = `FETCH_BUF_DEPTH;
   localparam int PW    = $clog2(DEPTH);
   localparam int CW    = $clog2(DEPTH + 1);

   pc_t           pc_mem    [DEPTH];
   instr_t        instr_mem [DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          pop;

   function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
      if (int'(ptr) == DEPTH - 1) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign issue_valid_o = (count != '0);
   assign issue_pc_o    = pc_mem[rd_ptr];
   assign issue_instr_o = instr_mem[rd_ptr];
   assign pop           = issue_valid_o && issue_ready_i;

   // Early stall, one fetch may still land after stall rises
   assign stall_o = (int'(count) + int'(push_i)) >= DEPTH - 1;

   ////////////////////////////////////////////////////////////
   // Pointers and occupancy
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({push_i, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         pc_mem[wr_ptr]    <= push_pc_i;
         instr_mem[wr_ptr] <= push_instr_i;
      end
   end

endmodule

// ==== src/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

////////////////////////////////////////////////////////////
// Instruction memory geometry
////////////////////////////////////////////////////////////

// Word address bits, 64 words
`define FETCH_IMEM_AW 6

////////////////////////////////////////////////////////////
// Issue buffer and pipeline constants
////////////////////////////////////////////////////////////

// Entries between fetch and decode
`define FETCH_BUF_DEPTH 4

// addi x0,x0,0 without the fixed 2'b11 opcode tail
`define FETCH_NOP_INSTR 30'd4

`endif

// ==== src/fetch_pkg.sv ====
`include "fetch_macros.svh"

package fetch_pkg;

   ////////////////////////////////////////////////////////////
   // Pipeline words
   ////////////////////////////////////////////////////////////

   // Instruction bits 31:2, low two bits are always 2'b11
   typedef logic [29:0] instr_t;

   // Word program counter, byte address bits 31:2
   typedef logic [29:0] pc_t;

   // Full data word as seen on the host bus
   typedef logic [31:0] word_t;

   // Word index into the instruction memory
   typedef logic [`FETCH_IMEM_AW-1:0] imem_addr_t;

   ////////////////////////////////////////////////////////////
   // AXI4-Lite response codes
   ////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      AXI_OKAY   = 2'b00,
      AXI_SLVERR = 2'b10
   } axi_resp_t;

endpackage

// ==== src/fetch_top.sv ====
module fetch_top
   import fetch_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,

   // Host AXI4-Lite slave
   input  word_t      s_awaddr_i,
   input  logic       s_awvalid_i,
   output logic       s_awready_o,
   input  word_t      s_wdata_i,
   input  logic [3:0] s_wstrb_i,
   input  logic       s_wvalid_i,
   output logic       s_wready_o,
   output axi_resp_t  s_bresp_o,
   output logic       s_bvalid_o,
   input  logic       s_bready_i,
   input  word_t      s_araddr_i,
   input  logic       s_arvalid_i,
   output logic       s_arready_o,
   output word_t      s_rdata_o,
   output axi_resp_t  s_rresp_o,
   output logic       s_rvalid_o,
   input  logic       s_rready_i,

   // Pipeline control
   input  logic       data_busywait_i,
   input  logic       branch_toggle_i,
   input  pc_t        branch_pc_i,
   output logic       ins_busywait_o,

   // Decode side
   output logic       issue_valid_o,
   output pc_t        issue_pc_o,
   output instr_t     issue_instr_o,
   input  logic       issue_ready_i
);

   logic       wr_en;
   imem_addr_t wr_addr;
   word_t      wr_data;
   imem_addr_t rd_addr;
   word_t      rd_data;
   imem_addr_t fetch_addr;
   word_t      fetch_data;
   logic       fetch_valid;
   pc_t        fetch_pc;
   instr_t     fetch_instr;
   logic       stall;

   ////////////////////////////////////////////////////////////
   // Program load and storage
   ////////////////////////////////////////////////////////////

   imem_axil_loader loader0 (
      .clk_i(clk_i), .rst_i(rst_i),
      .s_awaddr_i(s_awaddr_i), .s_awvalid_i(s_awvalid_i), .s_awready_o(s_awready_o),
      .s_wdata_i(s_wdata_i), .s_wstrb_i(s_wstrb_i),
      .s_wvalid_i(s_wvalid_i), .s_wready_o(s_wready_o),
      .s_bresp_o(s_bresp_o), .s_bvalid_o(s_bvalid_o), .s_bready_i(s_bready_i),
      .s_araddr_i(s_araddr_i), .s_arvalid_i(s_arvalid_i), .s_arready_o(s_arready_o),
      .s_rdata_o(s_rdata_o), .s_rresp_o(s_rresp_o),
      .s_rvalid_o(s_rvalid_o), .s_rready_i(s_rready_i),
      .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
      .rd_addr_o(rd_addr), .rd_data_i(rd_data)
   );

   instr_cache cache0 (
      .clk_i(clk_i),
      .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
      .rd_addr_i(rd_addr), .rd_data_o(rd_data),
      .fetch_addr_i(fetch_addr), .fetch_data_o(fetch_data)
   );

   ////////////////////////////////////////////////////////////
   // Fetch and issue
   ////////////////////////////////////////////////////////////

   instruction_fetch_stage fetch0 (
      .clk_i(clk_i), .rst_i(rst_i),
      .data_busywait_i(data_busywait_i), .stall_i(stall),
      .branch_toggle_i(branch_toggle_i), .branch_pc_i(branch_pc_i),
      .ins_busywait_o(ins_busywait_o),
      .fetch_addr_o(fetch_addr), .fetch_data_i(fetch_data),
      .valid_o(fetch_valid), .instr_o(fetch_instr), .pc_o(fetch_pc)
   );

   fetch_issue_buffer buf0 (
      .clk_i(clk_i), .rst_i(rst_i),
      .push_i(fetch_valid), .push_pc_i(fetch_pc), .push_instr_i(fetch_instr),
      .stall_o(stall),
      .issue_valid_o(issue_valid_o), .issue_pc_o(issue_pc_o),
      .issue_instr_o(issue_instr_o), .issue_ready_i(issue_ready_i)
   );

endmodule

// ==== src/imem_axil_loader.sv ====
`include "fetch_macros.svh"

module imem_axil_loader
   import fetch_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,

   // Write address channel
   input  word_t      s_awaddr_i,
   input  logic       s_awvalid_i,
   output logic       s_awready_o,

   // Write data channel
   input  word_t      s_wdata_i,
   input  logic [3:0] s_wstrb_i,
   input  logic       s_wvalid_i,
   output logic       s_wready_o,

   // Write response channel
   output axi_resp_t  s_bresp_o,
   output logic       s_bvalid_o,
   input  logic       s_bready_i,

   // Read address channel
   input  word_t      s_araddr_i,
   input  logic       s_arvalid_i,
   output logic       s_arready_o,

   // Read data channel
   output word_t      s_rdata_o,
   output axi_resp_t  s_rresp_o,
   output logic       s_rvalid_o,
   input  logic       s_rready_i,

   // Memory side
   output logic       wr_en_o,
   output imem_addr_t wr_addr_o,
   output word_t      wr_data_o,
   output imem_addr_t rd_addr_o,
   input  word_t      rd_data_i
);

   localparam int AW = `FETCH_IMEM_AW;

   logic       aw_full;
   logic       aw_ok;
   imem_addr_t aw_index;
   logic       w_full;
   word_t      w_data;
   logic       do_write;
   logic       ar_ok;

   ////////////////////////////////////////////////////////////
   // Write path
   ////////////////////////////////////////////////////////////

   // Both halves captured and the previous B already taken
   assign do_write  = aw_full && w_full && !s_bvalid_o;

   // Out of range writes still answer, but leave memory alone
   assign wr_en_o   = do_write && aw_ok;
   assign wr_addr_o = aw_index;
   assign wr_data_o = w_data;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         s_awready_o <= 1'b0;
         aw_full     <= 1'b0;
      end else begin
         s_awready_o <= s_awvalid_i && !s_awready_o && !aw_full;
         if (s_awvalid_i && s_awready_o) begin
            aw_full <= 1'b1;
         end else if (do_write) begin
            aw_full <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         s_wready_o <= 1'b0;
         w_full     <= 1'b0;
      end else begin
         s_wready_o <= s_wvalid_i && !s_wready_o && !w_full;
         if (s_wvalid_i && s_wready_o) begin
            w_full <= 1'b1;
         end else if (do_write) begin
            w_full <= 1'b0;
         end
      end
   end

   // Strobes ignored, every write is a full word
   always_ff @(posedge clk_i) begin
      if (s_awvalid_i && s_awready_o) begin
         aw_index <= s_awaddr_i[AW+1:2];
         aw_ok    <= (s_awaddr_i[31:AW+2] == '0);
      end
      if (s_wvalid_i && s_wready_o) begin
         w_data <= s_wdata_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         s_bvalid_o <= 1'b0;
         s_bresp_o  <= AXI_OKAY;
      end else if (do_write) begin
         s_bvalid_o <= 1'b1;
         s_bresp_o  <= aw_ok ? AXI_OKAY : AXI_SLVERR;
      end else if (s_bvalid_o && s_bready_i) begin
         s_bvalid_o <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Read path
   ////////////////////////////////////////////////////////////

   // Decoded straight from the bus, data sampled at the AR transfer
   assign rd_addr_o = s_araddr_i[AW+1:2];
   assign ar_ok     = (s_araddr_i[31:AW+2] == '0);

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         s_arready_o <= 1'b0;
         s_rvalid_o  <= 1'b0;
         s_rresp_o   <= AXI_OKAY;
      end else begin
         s_arready_o <= s_arvalid_i && !s_arready_o && !s_rvalid_o;
         if (s_arvalid_i && s_arready_o) begin
            s_rvalid_o <= 1'b1;
            s_rresp_o  <= ar_ok ? AXI_OKAY : AXI_SLVERR;
         end else if (s_rvalid_o && s_rready_i) begin
            s_rvalid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (s_arvalid_i && s_arready_o) begin
         s_rdata_o <= ar_ok ? rd_data_i : '0;
      end
   end

endmodule

// ==== src/instr_cache.sv ====
`include "fetch_macros.svh"

module instr_cache
   import fetch_pkg::*;
(
   input  logic       clk_i,

   // Host write port
   input  logic       wr_en_i,
   input  imem_addr_t wr_addr_i,
   input  word_t      wr_data_i,

   // Host read-back port
   input  imem_addr_t rd_addr_i,
   output word_t      rd_data_o,

   // Fetch read port
   input  imem_addr_t fetch_addr_i,
   output word_t      fetch_data_o
);

   localparam int DEPTH = 1 << `FETCH_IMEM_AW;

   word_t mem [DEPTH];

   ////////////////////////////////////////////////////////////
   // Synchronous write
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // Combinational reads
   ////////////////////////////////////////////////////////////

   assign rd_data_o    = mem[rd_addr_i];

   // Same-cycle data for the fetch counter
   assign fetch_data_o = mem[fetch_addr_i];

endmodule

// ==== src/instruction_fetch_stage.sv ====
`include "fetch_macros.svh"

module instruction_fetch_stage
   import fetch_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,

   // Hold conditions
   input  logic       data_busywait_i,
   input  logic       stall_i,

   // Redirect request, toggle protocol
   input  logic       branch_toggle_i,
   input  pc_t        branch_pc_i,
   output logic       ins_busywait_o,

   // Instruction memory
   output imem_addr_t fetch_addr_o,
   input  word_t      fetch_data_i,

   // Item toward the issue buffer
   output logic       valid_o,
   output instr_t     instr_o,
   output pc_t        pc_o
);

   pc_t  fetch_cnt;
   logic branch_ack;
   logic advance;

   ////////////////////////////////////////////////////////////
   // Redirect and advance conditions
   ////////////////////////////////////////////////////////////

   // Pending while the caller's toggle differs from the last one taken
   assign ins_busywait_o = branch_ack ^ branch_toggle_i;

   assign advance = !stall_i && !data_busywait_i;

   // Low counter bits index the memory directly
   assign fetch_addr_o = fetch_cnt[`FETCH_IMEM_AW-1:0];

   ////////////////////////////////////////////////////////////
   // Counter and control state
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         fetch_cnt  <= '0;
         // Start in step with the caller so reset fires no redirect
         branch_ack <= branch_toggle_i;
         valid_o    <= 1'b0;
      end else begin
         valid_o <= advance;
         if (advance) begin
            if (ins_busywait_o) begin
               fetch_cnt  <= branch_pc_i;
               branch_ack <= branch_toggle_i;
            end else begin
               fetch_cnt <= fetch_cnt + pc_t'(1);
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Output item
   ////////////////////////////////////////////////////////////

   // On redirect the abandoned word becomes a NOP at the old PC
   always_ff @(posedge clk_i) begin
      if (advance) begin
         pc_o <= fetch_cnt;
         if (ins_busywait_o) begin
            instr_o <= `FETCH_NOP_INSTR;
         end else begin
            instr_o <= fetch_data_i[31:2];
         end
      end
   end

endmodule

// ==== verilog.f ====
+incdir+src
src/fetch_pkg.sv
src/instr_cache.sv
src/imem_axil_loader.sv
src/instruction_fetch_stage.sv
src/fetch_issue_buffer.sv
src/fetch_top.sv
bench/fetch_tb.sv
